//--- test/decode_input.txt
# instr alu_op imm rd res_src invalid ebreak gap_ok (all hex)
# res_src 0 ALU 1 MEM 2 PC4 3 TGT 4 CSR 5 M, gap_ok lets an idle gap come before the line
00500093 0 00000005 01 0 0 0 1
0080a103 0 00000008 02 1 0 0 1
001101b3 0 00000001 03 0 0 0 0
0001a203 0 00000000 04 1 0 0 1
0042a223 0 00000004 04 0 0 0 0
0000a283 0 00000000 05 1 0 0 1
00500313 0 00000005 06 0 0 0 0
0000a003 0 00000000 00 1 0 0 1
000003b3 0 00000000 07 0 0 0 0
40110433 1 00000401 08 0 0 0 1
001154b3 6 00000001 09 0 0 0 1
40115533 7 00000401 0a 0 0 0 1
40315593 7 00000403 0b 0 0 0 1
00208463 a 00000008 08 0 0 0 1
fe20eee3 e fffffffc 1d 0 0 0 1
010000ef 0 00000010 01 2 0 0 1
004100e7 0 00000004 01 2 0 0 1
12345297 0 12345000 05 3 0 0 1
fffff337 0 fffff000 06 0 0 0 1
02208633 0 00000022 0c 5 0 0 1
0220c6b3 5 00000022 0d 5 0 0 1
00100073 0 00000001 00 4 0 1 1
00000073 0 00000000 00 4 0 0 1
00004501 0 00000000 0a 0 1 0 1
0000000b 0 00000000 00 0 1 0 1
00004073 0 00000000 00 4 1 0 1
30200073 0 00000302 00 4 1 0 1
06208633 0 00000062 0c 0 1 0 1
300110f3 0 00000300 01 4 0 0 1
0020f733 9 00000002 0e 0 0 0 1

//--- build.f
+incdir+include
rtl/rv_pkg.sv
rtl/rv_idec.sv
rtl/rv_alu_dec.sv
rtl/rv_hazard.sv
rtl/rv_id_stage.sv
test/rv_id_assert.sv
test/rv_id_tb.sv

//--- Makefile
TOOL   := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := rv_id_tb
FLIST  := build.f

SRCS   := $(shell grep -v '^+' $(FLIST))
HDRS   := $(wildcard include/*.svh)
BIN    := obj_dir/V$(TOP)
LOG    := sim.log
DATA   := test/decode_input.txt

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/rv_id_tb.sv
`timescale 1ns/100ps

module rv_id_tb
  import rv_pkg::*;
();

  localparam int MAX_ENTRIES = 64;
  localparam int MAX_CYCLES  = 2000;

  logic      clk;
  logic      arst_n;
  logic      fetch_valid;
  rv_instr_t fetch_instr;
  logic      stall;
  logic      ex_valid;
  rv_dec_t   ex_dec;
  rv_xlen_t  ex_imm;

  // Expected values per data file line
  logic [31:0] t_instr [MAX_ENTRIES];
  logic [3:0]  t_op    [MAX_ENTRIES];
  logic [31:0] t_imm   [MAX_ENTRIES];
  logic [4:0]  t_rd    [MAX_ENTRIES];
  logic [2:0]  t_res   [MAX_ENTRIES];
  logic        t_inv   [MAX_ENTRIES];
  logic        t_ebk   [MAX_ENTRIES];
  logic        t_gap   [MAX_ENTRIES];

  // Pipeline model holding the entry indices of IF/ID and ID/EX
  logic m_if_valid;
  logic m_ex_valid;
  int   m_if_idx;
  int   m_ex_idx;
  logic m_stall;

  integer seed = 32'had74_c747;
  int     n_entries;
  int     issue_idx;
  int     done_cnt;
  int     test_pass;
  int     test_fail;
  int     errors;
  int     stall_cnt;

  rv_id_stage UUT (
    .clk(clk), .arst_n(arst_n), .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
    .stall(stall), .ex_valid(ex_valid), .ex_dec(ex_dec), .ex_imm(ex_imm)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Register operands that each opcode reads
  function automatic logic reads_rs1(input logic [31:0] w);
    case (w[6:0])
      7'b0000011, 7'b0100011, 7'b0110011, 7'b0010011,
      7'b1100011, 7'b1100111: reads_rs1 = 1'b1;
      // CSR immediate forms put a zimm in the rs1 slot
      7'b1110011: reads_rs1 = !w[14];
      default: reads_rs1 = 1'b0;
    endcase
  endfunction

  function automatic logic reads_rs2(input logic [31:0] w);
    reads_rs2 = (w[6:0] == 7'b0100011) || (w[6:0] == 7'b0110011) || (w[6:0] == 7'b1100011);
  endfunction

  // Control bits that the opcode implies
  // Unknown opcodes give all zeros
  function automatic logic [9:0] expect_ctl(input logic [31:0] w);
    logic       wr;
    logic       b_imm;
    rv_alu_a_t  a_src;
    logic [6:0] op;
    op    = w[6:0];
    wr    = 1'b0;
    b_imm = 1'b0;
    a_src = ALU_A_RS1;
    case (op)
      // I-format opcodes take an immediate B operand and write rd
      7'b0000011, 7'b0010011, 7'b1100111, 7'b1110011: begin
        wr    = 1'b1;
        b_imm = 1'b1;
      end
      7'b0100011: b_imm = 1'b1;
      7'b0110011: wr = 1'b1;
      // JAL and AUIPC add to the PC
      7'b1101111, 7'b0010111: begin
        wr    = 1'b1;
        b_imm = 1'b1;
        a_src = ALU_A_PC;
      end
      // LUI adds its immediate to zero
      7'b0110111: begin
        wr    = 1'b1;
        b_imm = 1'b1;
        a_src = ALU_A_ZERO;
      end
      default: wr = 1'b0;
    endcase
    // ECALL and EBREAK touch no CSR
    expect_ctl = {wr, (op == 7'b0000011), (op == 7'b0100011), a_src, b_imm,
                  (op == 7'b1100011), (op == 7'b1101111), (op == 7'b1100111),
                  ((op == 7'b1110011) && (w[14:12] != 3'b000))};
  endfunction

  // Load in EX feeding the instruction in ID
  function automatic logic predict_stall();
    logic [31:0] wi;
    logic [31:0] we;
    wi = t_instr[m_if_idx];
    we = t_instr[m_ex_idx];
    predict_stall = m_if_valid && m_ex_valid && (we[6:0] == 7'b0000011) &&
                    (we[11:7] != 5'd0) &&
                    ((reads_rs1(wi) && (wi[19:15] == we[11:7])) ||
                     (reads_rs2(wi) && (wi[24:20] == we[11:7])));
  endfunction

  task automatic load_vectors();
    int fd;
    int cnt;
    logic [8*160-1:0] line;
    logic [31:0] v [8];
    n_entries = 0;
    fd = $fopen("test/decode_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/decode_input.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
        line = '0;
        cnt = $fgets(line, fd);
        // Comment and blank lines scan short
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        if (cnt == 8) begin
          t_instr[n_entries] = v[0];
          t_op[n_entries]    = v[1][3:0];
          t_imm[n_entries]   = v[2];
          t_rd[n_entries]    = v[3][4:0];
          t_res[n_entries]   = v[4][2:0];
          t_inv[n_entries]   = v[5][0];
          t_ebk[n_entries]   = v[6][0];
          t_gap[n_entries]   = v[7][0];
          n_entries++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Next word or an idle gap
  // A word not yet taken stays on the bus
  task automatic present_fetch(input logic held);
    if (held) begin
      fetch_valid = 1'b1;
    end else if (issue_idx >= n_entries) begin
      fetch_valid = 1'b0;
      fetch_instr = '0;
    end else if (t_gap[issue_idx] && (($random(seed) & 3) == 0)) begin
      fetch_valid = 1'b0;
      fetch_instr = '0;
    end else begin
      fetch_valid = 1'b1;
      fetch_instr = t_instr[issue_idx];
    end
  endtask

  task automatic check_entry(input int i);
    string      name;
    logic       bad;
    logic [9:0] exp_ctl;
    logic [9:0] got_ctl;
    name = $sformatf("entry %0d (%h)", i, t_instr[i]);
    bad = 1'b0;
    exp_ctl = expect_ctl(t_instr[i]);
    got_ctl = {ex_dec.reg_write, ex_dec.mem_read, ex_dec.mem_write, ex_dec.alu_a,
               ex_dec.alu_b_imm, ex_dec.is_branch, ex_dec.is_jal, ex_dec.is_jalr,
               ex_dec.is_csr};
    assert (ex_valid === 1'b1) else begin
      $display("[FAIL] %s ex_valid: expected 1, actual %b", name, ex_valid);
      bad = 1'b1;
    end
    assert (ex_imm === t_imm[i]) else begin
      $display("[FAIL] %s imm: expected %h, actual %h", name, t_imm[i], ex_imm);
      bad = 1'b1;
    end
    assert (ex_dec.rd === t_rd[i]) else begin
      $display("[FAIL] %s rd: expected %h, actual %h", name, t_rd[i], ex_dec.rd);
      bad = 1'b1;
    end
    assert (4'(ex_dec.alu_op) === t_op[i]) else begin
      $display("[FAIL] %s alu_op: expected %h, actual %h", name, t_op[i], ex_dec.alu_op);
      bad = 1'b1;
    end
    assert (3'(ex_dec.res_src) === t_res[i]) else begin
      $display("[FAIL] %s res_src: expected %h, actual %h", name, t_res[i], ex_dec.res_src);
      bad = 1'b1;
    end
    assert (ex_dec.invalid === t_inv[i]) else begin
      $display("[FAIL] %s invalid: expected %b, actual %b", name, t_inv[i], ex_dec.invalid);
      bad = 1'b1;
    end
    assert (ex_dec.is_ebreak === t_ebk[i]) else begin
      $display("[FAIL] %s is_ebreak: expected %b, actual %b", name, t_ebk[i],
               ex_dec.is_ebreak);
      bad = 1'b1;
    end
    assert (got_ctl === exp_ctl) else begin
      $display("[FAIL] %s control: expected %b, actual %b", name, exp_ctl, got_ctl);
      bad = 1'b1;
    end
    // Register fields sit at fixed places in every format
    assert ((ex_dec.rs1 === t_instr[i][19:15]) &&
            (ex_dec.rs2 === t_instr[i][24:20])) else begin
      $display("[FAIL] %s rs1 rs2: expected %h %h, actual %h %h", name, t_instr[i][19:15],
               t_instr[i][24:20], ex_dec.rs1, ex_dec.rs2);
      bad = 1'b1;
    end
    if (bad) begin
      test_fail++;
      $display("%s finished with errors", name);
    end else begin
      test_pass++;
      $display("%s ok", name);
    end
  endtask

  initial begin
    int   cycles;
    logic accept;
    logic held;
    arst_n      = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    errors      = 0;
    test_pass   = 0;
    test_fail   = 0;
    stall_cnt   = 0;
    done_cnt    = 0;
    issue_idx   = 0;
    m_if_valid  = 1'b0;
    m_ex_valid  = 1'b0;
    m_if_idx    = 0;
    m_ex_idx    = 0;
    load_vectors();
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    @(negedge clk);
    // Reset leaves both valid flags clear
    assert ((ex_valid === 1'b0) && (stall === 1'b0)) else begin
      $display("[FAIL] reset: expected ex_valid 0 stall 0, actual %b %b", ex_valid, stall);
      errors++;
    end
    $display("reset check finished");
    @(posedge clk);
    #1 present_fetch(1'b0);
    cycles = 0;
    while ((done_cnt < n_entries) && (cycles < MAX_CYCLES)) begin
      @(negedge clk);
      cycles++;
      m_stall = predict_stall();
      if (m_stall) stall_cnt++;
      assert (stall === m_stall) else begin
        $display("[FAIL] stall cycle %0d: expected %b, actual %b", cycles, m_stall, stall);
        errors++;
      end
      if (m_ex_valid) begin
        check_entry(m_ex_idx);
        done_cnt++;
      end else begin
        // Idle gap or stall bubble
        assert (ex_valid === 1'b0) else begin
          $display("[FAIL] bubble cycle %0d: expected ex_valid 0, actual %b", cycles, ex_valid);
          errors++;
        end
      end
      accept = fetch_valid && !m_stall;
      held   = fetch_valid && !accept;
      @(posedge clk);
      m_ex_valid = m_if_valid && !m_stall;
      m_ex_idx   = m_if_idx;
      if (!m_stall) begin
        m_if_valid = fetch_valid;
        m_if_idx   = issue_idx;
      end
      #1;
      if (accept) issue_idx++;
      present_fetch(held);
    end
    if (done_cnt < n_entries) begin
      $display("Timed out after %0d cycles with %0d of %0d entries out", cycles, done_cnt,
               n_entries);
      errors++;
    end
    errors = errors + test_fail;
    $display("Tests passed %0d, failed %0d, stall cycles %0d, other errors %0d",
             test_pass, test_fail, stall_cnt, errors - test_fail);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- test/rv_id_assert.sv
`timescale 1ns/100ps

module rv_id_assert (
  input logic clk,
  input logic arst_n,
  input logic if_valid,
  input logic stall,
  input logic ex_valid
);

  // Stall only for a real instruction in IF/ID
  a_stall_needs_id: assert property (@(posedge clk) disable iff (!arst_n)
    stall |-> if_valid)
    else $error("stall high with IF/ID empty");

  // Stall pushes a bubble into ID/EX
  a_stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
    stall |=> !ex_valid)
    else $error("ex_valid high after stall");

  // The load leaves ID/EX, so one cycle is enough
  a_stall_single: assert property (@(posedge clk) disable iff (!arst_n)
    stall |=> !stall)
    else $error("stall lasted two cycles");

  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !ex_valid)
    else $error("ex_valid high in reset");

endmodule

bind rv_id_stage rv_id_assert u_assert (
  .clk(clk), .arst_n(arst_n), .if_valid(if_valid), .stall(stall), .ex_valid(ex_valid)
);

//--- rtl/rv_id_stage.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_id_stage
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      fetch_valid,
  input  rv_instr_t fetch_instr,
  output logic      stall,
  output logic      ex_valid,
  output rv_dec_t   ex_dec,
  output rv_xlen_t  ex_imm
);

  // IF/ID register
  logic      if_valid;
  rv_instr_t if_instr;

  // Decoder outputs
  logic          id_reg_write;
  logic          id_mem_read;
  logic          id_mem_write;
  rv_alu_a_t     id_alu_a;
  logic          id_alu_b_imm;
  rv_alu_class_t id_alu_class;
  rv_res_t       id_res_src;
  rv_imm_t       id_imm_type;
  logic          id_is_branch;
  logic          id_is_jal;
  logic          id_is_jalr;
  logic          id_is_csr;
  logic          id_is_ebreak;
  logic          id_invalid;
  rv_reg_t       id_rd;
  rv_reg_t       id_rs1;
  rv_reg_t       id_rs2;
  logic [2:0]    id_funct3;
  logic [6:0]    id_funct7;
  logic          id_rs1_used;
  logic          id_rs2_used;
  rv_xlen_t      id_imm_i;
  rv_xlen_t      id_imm_s;
  rv_xlen_t      id_imm_b;
  rv_xlen_t      id_imm_u;
  rv_xlen_t      id_imm_j;
  rv_alu_op_t    id_alu_op;
  rv_dec_t       id_dec;
  rv_xlen_t      id_imm;

  rv_idec u_idec (
    .instr(if_instr), .reg_write(id_reg_write), .mem_read(id_mem_read),
    .mem_write(id_mem_write), .alu_a(id_alu_a), .alu_b_imm(id_alu_b_imm),
    .alu_class(id_alu_class), .res_src(id_res_src), .imm_type(id_imm_type),
    .is_branch(id_is_branch), .is_jal(id_is_jal), .is_jalr(id_is_jalr),
    // M ops already reach EX through res_src
    .is_m(), .is_csr(id_is_csr), .is_ebreak(id_is_ebreak),
    .instr_invalid(id_invalid), .rd(id_rd), .rs1(id_rs1), .rs2(id_rs2),
    .funct3(id_funct3), .funct7(id_funct7), .rs1_used(id_rs1_used),
    .rs2_used(id_rs2_used), .imm_i(id_imm_i), .imm_s(id_imm_s),
    .imm_b(id_imm_b), .imm_u(id_imm_u), .imm_j(id_imm_j)
  );

  // R-type is the only FN3 class with a register B operand
  rv_alu_dec u_alu_dec (
    .alu_class(id_alu_class), .funct3(id_funct3), .funct7(id_funct7),
    .is_rtype((id_alu_class == ALU_CLS_FN3) && !id_alu_b_imm), .alu_op(id_alu_op)
  );

  rv_hazard u_hazard (
    .id_valid(if_valid), .rs1(id_rs1), .rs2(id_rs2), .rs1_used(id_rs1_used),
    .rs2_used(id_rs2_used), .ex_valid(ex_valid), .ex_mem_read(ex_dec.mem_read),
    .ex_rd(ex_dec.rd), .stall(stall)
  );

  // Immediate chosen by format
  always_comb begin
    case (id_imm_type)
      IMM_I:   id_imm = id_imm_i;
      IMM_S:   id_imm = id_imm_s;
      IMM_B:   id_imm = id_imm_b;
      IMM_U:   id_imm = id_imm_u;
      IMM_J:   id_imm = id_imm_j;
      default: id_imm = {`RV_XLEN{1'b0}};
    endcase
  end

  assign id_dec = '{
    reg_write: id_reg_write, mem_read: id_mem_read, mem_write: id_mem_write,
    alu_a: id_alu_a, alu_b_imm: id_alu_b_imm, alu_op: id_alu_op,
    res_src: id_res_src, is_branch: id_is_branch, is_jal: id_is_jal,
    is_jalr: id_is_jalr, is_csr: id_is_csr, is_ebreak: id_is_ebreak,
    invalid: id_invalid, rd: id_rd, rs1: id_rs1, rs2: id_rs2
  };

  // IF/ID holds on stall, ID/EX takes a bubble instead
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_valid <= 1'b0;
      ex_valid <= 1'b0;
    end else begin
      if (!stall) begin
        if_valid <= fetch_valid;
      end
      ex_valid <= if_valid && !stall;
    end
  end

  // Payload only, qualified by the valid flags
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_instr <= fetch_instr;
    end
    ex_dec <= id_dec;
    ex_imm <= id_imm;
  end

endmodule

//--- rtl/rv_hazard.sv
`timescale 1ns/100ps

module rv_hazard
  import rv_pkg::*;
(
  // Instruction sitting in IF/ID
  input  logic    id_valid,
  input  rv_reg_t rs1,
  input  rv_reg_t rs2,
  input  logic    rs1_used,
  input  logic    rs2_used,
  // Instruction sitting in ID/EX
  input  logic    ex_valid,
  input  logic    ex_mem_read,
  input  rv_reg_t ex_rd,
  output logic    stall
);

  logic ex_load;
  logic hit_rs1;
  logic hit_rs2;

  // A load whose result is not ready until after MEM
  // Writes to x0 are dropped, so they never create a dependence
  assign ex_load = ex_valid && ex_mem_read && (ex_rd != 5'd0);

  // Raw rs fields may be immediate bits, the used flags filter them
  assign hit_rs1 = rs1_used && (rs1 == ex_rd);
  assign hit_rs2 = rs2_used && (rs2 == ex_rd);

  // One cycle of stall, the load then moves past ID/EX
  assign stall = id_valid && ex_load && (hit_rs1 || hit_rs2);

endmodule

//--- rtl/rv_alu_dec.sv
`timescale 1ns/100ps

module rv_alu_dec
  import rv_pkg::*;
(
  input  rv_alu_class_t alu_class,
  input  logic [2:0]    funct3,
  input  logic [6:0]    funct7,
  input  logic          is_rtype,
  output rv_alu_op_t    alu_op
);

  // Alternate encoding, SUB for R-type and SRA for any shift right
  logic alt;

  assign alt = (funct7 == 7'b0100000);

  always_comb begin
    alu_op = ALU_ADD;
    case (alu_class)
      // Address and immediate-add users
      ALU_CLS_ADD: alu_op = ALU_ADD;
      // Branch compares straight from funct3
      ALU_CLS_BR: begin
        case (funct3)
          3'b000:  alu_op = ALU_EQ;
          3'b001:  alu_op = ALU_NE;
          3'b100:  alu_op = ALU_LT;
          3'b101:  alu_op = ALU_GE;
          3'b110:  alu_op = ALU_LTU;
          3'b111:  alu_op = ALU_GEU;
          default: alu_op = ALU_EQ;
        endcase
      end
      ALU_CLS_FN3: begin
        case (funct3)
          // ADDI carries imm bits in funct7, so SUB needs R-type
          3'b000:  alu_op = (is_rtype && alt) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      default: alu_op = ALU_ADD;
    endcase
  end

endmodule

//--- rtl/rv_idec.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_idec
  import rv_pkg::*;
(
  input  rv_instr_t     instr,

  output logic          reg_write,
  output logic          mem_read,
  output logic          mem_write,
  output rv_alu_a_t     alu_a,
  output logic          alu_b_imm,
  output rv_alu_class_t alu_class,
  output rv_res_t       res_src,
  output rv_imm_t       imm_type,
  output logic          is_branch,
  output logic          is_jal,
  output logic          is_jalr,
  output logic          is_m,
  output logic          is_csr,
  output logic          is_ebreak,
  output logic          instr_invalid,

  output rv_reg_t       rd,
  output rv_reg_t       rs1,
  output rv_reg_t       rs2,
  output logic [2:0]    funct3,
  output logic [6:0]    funct7,
  output logic          rs1_used,
  output logic          rs2_used,

  output rv_xlen_t      imm_i,
  output rv_xlen_t      imm_s,
  output rv_xlen_t      imm_b,
  output rv_xlen_t      imm_u,
  output rv_xlen_t      imm_j
);

  // Whole-word encodings of the two supported privileged calls
  localparam rv_instr_t ECALL_WORD  = 32'h0000_0073;
  localparam rv_instr_t EBREAK_WORD = 32'h0010_0073;

  // Short names so each table row reads at a glance
  localparam logic y = 1'b1;
  localparam logic n = 1'b0;
  localparam rv_alu_a_t RS1 = ALU_A_RS1;
  localparam rv_alu_a_t ZRO = ALU_A_ZERO;
  localparam rv_alu_a_t PC = ALU_A_PC;
  localparam rv_alu_class_t ADD = ALU_CLS_ADD;
  localparam rv_alu_class_t FN3 = ALU_CLS_FN3;
  localparam rv_alu_class_t BR = ALU_CLS_BR;
  localparam rv_res_t ALU = RES_ALU;
  localparam rv_res_t MEM = RES_MEM;
  localparam rv_res_t PC4 = RES_PC4;
  localparam rv_res_t TGT = RES_TGT;
  localparam rv_res_t CSR = RES_CSR;
  localparam rv_imm_t I = IMM_I;
  localparam rv_imm_t S = IMM_S;
  localparam rv_imm_t B = IMM_B;
  localparam rv_imm_t U = IMM_U;
  localparam rv_imm_t J = IMM_J;

  // One decode table row
  typedef struct packed {
    logic          valid;
    logic          reg_write;
    logic          mem_read;
    logic          mem_write;
    rv_alu_a_t     alu_a;
    logic          alu_b_imm;
    rv_alu_class_t alu_class;
    rv_res_t       res_src;
    rv_imm_t       imm_type;
    logic          is_branch;
    logic          is_jal;
    logic          is_jalr;
    logic          is_csr;
    logic          rs1_used;
    logic          rs2_used;
  } ctl_t;

  rv_opcode_t opcode;
  ctl_t       ctl;
  logic       inv_system;
  logic       inv_m;

  assign opcode = rv_opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  // rs fields are passed out raw, the used flags say whether they matter
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  always_comb begin
    case (opcode)
      //                v  rw mr mw  a    bi cls  res  imm br jl jr cs u1 u2
      OP_LOAD:   ctl = {y, y, y, n, RS1, y, ADD, MEM, I, n, n, n, n, y, n};
      OP_STORE:  ctl = {y, n, n, y, RS1, y, ADD, ALU, S, n, n, n, n, y, y};
      OP_RTYPE:  ctl = {y, y, n, n, RS1, n, FN3, ALU, I, n, n, n, n, y, y};
      OP_ITYPE:  ctl = {y, y, n, n, RS1, y, FN3, ALU, I, n, n, n, n, y, n};
      OP_BRANCH: ctl = {y, n, n, n, RS1, n, BR,  ALU, B, y, n, n, n, y, y};
      OP_JAL:    ctl = {y, y, n, n, PC,  y, ADD, PC4, J, n, y, n, n, n, n};
      OP_JALR:   ctl = {y, y, n, n, RS1, y, ADD, PC4, I, n, n, y, n, y, n};
      OP_AUIPC:  ctl = {y, y, n, n, PC,  y, ADD, TGT, U, n, n, n, n, n, n};
      OP_LUI:    ctl = {y, y, n, n, ZRO, y, ADD, ALU, U, n, n, n, n, n, n};
      OP_SYSTEM: ctl = {y, y, n, n, RS1, y, ADD, CSR, I, n, n, n, y, y, n};
      // Unknown opcode, valid bit low
      default:   ctl = '0;
    endcase
  end

  assign reg_write = ctl.reg_write;
  assign mem_read  = ctl.mem_read;
  assign mem_write = ctl.mem_write;
  assign alu_a     = ctl.alu_a;
  assign alu_b_imm = ctl.alu_b_imm;
  assign alu_class = ctl.alu_class;
  assign imm_type  = ctl.imm_type;
  assign is_branch = ctl.is_branch;
  assign is_jal    = ctl.is_jal;
  assign is_jalr   = ctl.is_jalr;
  assign rs2_used  = ctl.rs2_used;

  // Multiply/divide takes its result from the M unit
  assign res_src = is_m ? RES_M : ctl.res_src;

  // Immediate CSR forms hold a zimm in the rs1 slot
  assign rs1_used = ctl.rs1_used && !(ctl.is_csr && funct3[2]);
  // ECALL and EBREAK share the SYSTEM opcode but touch no CSR
  assign is_csr   = ctl.is_csr && (funct3 != 3'b000);

  // Sign extended immediates, B and J are halfword aligned
  assign imm_i = {{(`RV_XLEN - 12) {instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN - 12) {instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`RV_XLEN - 12) {instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN - 32) {instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN - 20) {instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // Only funct7 0000001 exactly is a real M encoding
  if (`RV_EXT_M != 0) begin : g_m
    assign is_m  = (opcode == OP_RTYPE) && (funct7 == 7'b0000001);
    assign inv_m = (opcode == OP_RTYPE) && funct7[0] && (funct7 != 7'b0000001);
  end else begin : g_no_m
    assign is_m  = 1'b0;
    assign inv_m = (opcode == OP_RTYPE) && funct7[0];
  end

  // Full word compare here keeps it out of later stages
  assign is_ebreak = (instr == EBREAK_WORD);

  // funct3 100 is reserved, funct3 000 allows only ECALL/EBREAK
  assign inv_system = (opcode == OP_SYSTEM) &&
                      ((funct3 == 3'b100) ||
                       ((funct3 == 3'b000) && (instr != ECALL_WORD) &&
                        (instr != EBREAK_WORD)));

  // Compressed words fail the low-bits check
  assign instr_invalid = (instr[1:0] != 2'b11) || !ctl.valid || inv_system || inv_m;

endmodule

//--- rtl/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // Plain word types
  typedef logic [31:0] rv_instr_t;
  typedef logic [`RV_XLEN-1:0] rv_xlen_t;
  typedef logic [4:0] rv_reg_t;

  // Base opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_ITYPE  = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_RTYPE  = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } rv_opcode_t;

  // ALU operand A source
  typedef enum logic [1:0] {
    ALU_A_RS1  = 2'd0,
    ALU_A_ZERO = 2'd1,
    ALU_A_PC   = 2'd2
  } rv_alu_a_t;

  // How the ALU decoder reads funct3/funct7
  typedef enum logic [1:0] {
    ALU_CLS_ADD = 2'd0,
    ALU_CLS_FN3 = 2'd1,
    ALU_CLS_BR  = 2'd2
  } rv_alu_class_t;

  // Writeback result source
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_PC4 = 3'd2,
    RES_TGT = 3'd3,
    RES_CSR = 3'd4,
    RES_M   = 3'd5
  } rv_res_t;

  // Immediate format
  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } rv_imm_t;

  // Concrete ALU operation, compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } rv_alu_op_t;

  // Decoded control bundle carried in ID/EX
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    rv_alu_a_t  alu_a;
    logic       alu_b_imm;
    rv_alu_op_t alu_op;
    rv_res_t    res_src;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_csr;
    logic       is_ebreak;
    logic       invalid;
    rv_reg_t    rd;
    rv_reg_t    rs1;
    rv_reg_t    rs2;
  } rv_dec_t;

endpackage

//--- include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Architectural data width
// Only RV32 is decoded, so this stays at 32
`define RV_XLEN 32

// Multiply/divide decode
// 1 decodes MUL/DIV/REM as valid with result source M
// 0 flags every funct7 0000001 R-type as invalid
`define RV_EXT_M 1

// Compressed words are always flagged invalid
// Immediates are sign extended from bit 31 up to RV_XLEN

`endif
